//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ADC frontend simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module adc_frontend_tb -f vlog.f -o adc_frontend_sim &&
./obj_dir/adc_frontend_sim | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation succeeded" ||
{ echo "Simulation did not succeed"; exit 1; }

//--- source/adc_frontend.sv
`timescale 1ns/1ps
`default_nettype none

// Top of the ADC sample conditioning path
// Raw samples go through offset and gain correction, then block averaging
module adc_frontend #(
    parameter int DATA_WIDTH = 16,
    parameter int DECIMATION_LOG2 = 2
) (
    input wire logic clock,
    input wire logic rst,
    input wire logic flush,
    input wire logic signed [DATA_WIDTH-1:0] in_data,
    input wire logic in_valid,
    output logic in_ready,
    input wire logic out_ready,
    output logic signed [DATA_WIDTH-1:0] out_data,
    output logic out_valid,
    input wire logic config_write,
    input wire adc_pkg::config_address_t config_address,
    input wire logic [adc_pkg::config_data_width-1:0] config_data
);

    import adc_pkg::*;

    // Live settings from the register block
    calibration_config_t settings;

    // Corrected samples travelling to the averager
    logic signed [DATA_WIDTH-1:0] calibrated_data;
    logic calibrated_valid;

    // Settings are untouched by flush, only rst brings them back to defaults
    calibration_registers settings_registers (
        .clock(clock),
        .rst(rst),
        .config_write(config_write),
        .config_address(config_address),
        .config_data(config_data),
        .settings(settings)
    );

    calibration #(
        .DATA_WIDTH(DATA_WIDTH)
    ) calibration_stage (
        .clock(clock),
        .rst(rst),
        .flush(flush),
        .settings(settings),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_ready(out_ready),
        .calibrated_data(calibrated_data),
        .calibrated_valid(calibrated_valid)
    );

    // The averager has no ready input and takes every calibrated pulse
    decimator #(
        .DATA_WIDTH(DATA_WIDTH),
        .DECIMATION_LOG2(DECIMATION_LOG2)
    ) averager (
        .clock(clock),
        .rst(rst),
        .flush(flush),
        .calibrated_data(calibrated_data),
        .calibrated_valid(calibrated_valid),
        .out_data(out_data),
        .out_valid(out_valid)
    );

endmodule

`default_nettype wire

//--- source/adc_pkg.sv
`default_nettype none

// Shared types and constants for the ADC conditioning path
package adc_pkg;

    // Width of the offset field, which is also the natural width of a raw sample
    localparam int offset_width = 16;

    // Largest useful left shift is 15, so four bits are enough
    localparam int gain_shift_width = 4;

    // Write data on the settings port is as wide as the offset register
    localparam int config_data_width = 16;

    // Live calibration settings as seen by the calibration stage
    // The offset is signed and gets sign-extended to the sample width downstream
    typedef struct packed {
        logic signed [offset_width-1:0] offset;
        logic [gain_shift_width-1:0] gain_shift;
        logic gain_enable;
    } calibration_config_t;

    // Register map of the strobe write port
    // Address 3 is left unmapped on purpose and writes to it are dropped
    typedef enum logic [1:0] {
        address_offset = 2'd0,
        address_shift = 2'd1,
        address_control = 2'd2
    } config_address_t;

    // Power-up settings, a transparent path with zero offset and no gain
    localparam calibration_config_t config_reset_value = '{
        offset: '0,
        gain_shift: '0,
        gain_enable: 1'b0
    };

endpackage

`default_nettype wire

//--- source/calibration.sv
`timescale 1ns/1ps
`default_nettype none

// Offset and gain correction of the raw ADC samples
// One register stage deep, each accepted sample comes out one cycle later
module calibration #(
    parameter int DATA_WIDTH = 16
) (
    input wire logic clock,
    input wire logic rst,
    input wire logic flush,
    input wire adc_pkg::calibration_config_t settings,
    input wire logic signed [DATA_WIDTH-1:0] in_data,
    input wire logic in_valid,
    output logic in_ready,
    input wire logic out_ready,
    output logic signed [DATA_WIDTH-1:0] calibrated_data,
    output logic calibrated_valid
);

    // Offset brought to the sample width
    logic signed [DATA_WIDTH-1:0] offset_extended;

    // Sample plus offset after clamping at the rails
    logic signed [DATA_WIDTH-1:0] offset_sum;

    // Value after the optional power-of-two gain
    logic signed [DATA_WIDTH-1:0] gain_corrected;

    // High in a cycle where the source hands over a sample
    logic accept;

    // The stage never stalls on its own
    // Input readiness is just the sink's permission
    assign in_ready = out_ready;

    assign accept = in_valid & in_ready;

    // Sign extension of the 16 bit offset up to the sample width
    assign offset_extended = DATA_WIDTH'(settings.offset);

    // The offset is applied with saturation so that a large
    // correction pins the sample to a rail instead of wrapping
    saturating_adder #(
        .DATA_WIDTH(DATA_WIDTH)
    ) offset_adder (
        .a(in_data),
        .b(offset_extended),
        .sum(offset_sum)
    );

    always_comb begin
        // The gain is a plain left shift
        // Bits pushed past the top are lost so the value wraps in two's complement
        if (settings.gain_enable) begin
            gain_corrected = offset_sum <<< settings.gain_shift;
        end else begin
            gain_corrected = offset_sum;
        end
    end

    // Valid flag of the output register
    // Flush drops whatever sample sits in the stage
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            calibrated_valid <= 1'b0;
        end else begin
            calibrated_valid <= accept;
        end
    end

    // Data register, only loaded when a sample is accepted
    // Its content is meaningless while calibrated_valid is low
    always_ff @(posedge clock) begin
        if (accept) begin
            calibrated_data <= gain_corrected;
        end
    end

endmodule

`default_nettype wire

//--- source/calibration_registers.sv
`timescale 1ns/1ps
`default_nettype none

// Settings registers of the calibration stage
// Written one field at a time through a strobe port, no readback
module calibration_registers (
    input wire logic clock,
    input wire logic rst,
    input wire logic config_write,
    input wire adc_pkg::config_address_t config_address,
    input wire logic [adc_pkg::config_data_width-1:0] config_data,
    output adc_pkg::calibration_config_t settings
);

    import adc_pkg::*;

    // Field values that the write strobe would load
    calibration_config_t settings_next;

    always_comb begin
        // By default every field holds its value
        settings_next = settings;

        case (config_address)
            address_offset: begin
                settings_next.offset = signed'(config_data[offset_width-1:0]);
            end
            address_shift: begin
                // Only the low bits matter, the rest of the word is ignored
                settings_next.gain_shift = config_data[gain_shift_width-1:0];
            end
            address_control: begin
                settings_next.gain_enable = config_data[0];
            end
            default: begin
                // Address 3 is not mapped, so the settings stay as they are
                settings_next = settings;
            end
        endcase
    end

    // The register is updated at the edge that sees the strobe
    // and the new value reaches the calibration stage in the next cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            settings <= config_reset_value;
        end else if (config_write) begin
            settings <= settings_next;
        end
    end

endmodule

`default_nettype wire

//--- source/decimator.sv
`timescale 1ns/1ps
`default_nettype none

// Block averager
// Sums groups of 2^DECIMATION_LOG2 calibrated samples and emits the floor of their mean
module decimator #(
    parameter int DATA_WIDTH = 16,
    parameter int DECIMATION_LOG2 = 2
) (
    input wire logic clock,
    input wire logic rst,
    input wire logic flush,
    input wire logic signed [DATA_WIDTH-1:0] calibrated_data,
    input wire logic calibrated_valid,
    output logic signed [DATA_WIDTH-1:0] out_data,
    output logic out_valid
);

    // The accumulator needs DECIMATION_LOG2 guard bits to hold the full group sum
    localparam int sum_width = DATA_WIDTH + DECIMATION_LOG2;

    // With no decimation a single bit counter is kept, it just never leaves zero
    localparam int count_width = (DECIMATION_LOG2 > 0) ? DECIMATION_LOG2 : 1;

    // Number of samples in one group
    localparam int group_size = 1 << DECIMATION_LOG2;

    // Counter value of the last sample of a group
    localparam logic [count_width-1:0] last_count = count_width'(group_size - 1);

    // Partial sum of the group in progress
    logic signed [sum_width-1:0] accumulator;

    // Index of the next sample within its group
    logic [count_width-1:0] sample_count;

    // Sum including the sample on the input this cycle
    logic signed [sum_width-1:0] sum_next;

    // The incoming sample closes the current group
    logic group_done;

    // Floor mean of the finished group
    logic signed [DATA_WIDTH-1:0] mean;

    always_comb begin
        // Sign extension of the sample before it joins the sum
        sum_next = accumulator + sum_width'(calibrated_data);

        group_done = calibrated_valid && (sample_count == last_count);

        // Arithmetic shift rounds toward minus infinity, which gives the floor
        // The quotient always fits back into DATA_WIDTH bits
        mean = DATA_WIDTH'(sum_next >>> DECIMATION_LOG2);
    end

    // Counter and accumulator
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            sample_count <= '0;
            accumulator <= '0;
        end else if (calibrated_valid) begin
            if (group_done) begin
                // The next group starts from an empty sum in the same edge,
                // so a sample arriving right after is not lost
                sample_count <= '0;
                accumulator <= '0;
            end else begin
                sample_count <= sample_count + 1'b1;
                accumulator <= sum_next;
            end
        end
    end

    // Result pulse lasts one cycle
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= group_done;
        end
    end

    // Result register is only written at the end of a group
    always_ff @(posedge clock) begin
        if (group_done) begin
            out_data <= mean;
        end
    end

endmodule

`default_nettype wire

//--- source/saturating_adder.sv
`timescale 1ns/1ps
`default_nettype none

// Signed adder whose result is clamped to the range of DATA_WIDTH bits
module saturating_adder #(
    parameter int DATA_WIDTH = 16
) (
    input wire logic signed [DATA_WIDTH-1:0] a,
    input wire logic signed [DATA_WIDTH-1:0] b,
    output logic signed [DATA_WIDTH-1:0] sum
);

    // Rail values follow from the width alone
    localparam logic signed [DATA_WIDTH-1:0] max_positive = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam logic signed [DATA_WIDTH-1:0] max_negative = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    // One extra bit holds every possible sum of two DATA_WIDTH operands
    logic signed [DATA_WIDTH:0] wide_sum;

    always_comb begin
        // Size casts of signed operands sign-extend them
        wide_sum = (DATA_WIDTH+1)'(a) + (DATA_WIDTH+1)'(b);

        // The sum only overflowed when its two top bits disagree
        if (wide_sum[DATA_WIDTH] != wide_sum[DATA_WIDTH-1]) begin
            // The extra bit carries the true sign of the result
            if (wide_sum[DATA_WIDTH]) begin
                sum = max_negative;
            end else begin
                sum = max_positive;
            end
        end else begin
            sum = wide_sum[DATA_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- verif/adc_frontend_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Concurrent checks on the top level of the conditioning path
module adc_frontend_assertions #(
    parameter int DECIMATION_LOG2 = 2
) (
    input wire logic clock,
    input wire logic rst,
    input wire logic flush,
    input wire logic in_ready,
    input wire logic out_ready,
    input wire logic out_valid
);

    // Shortest legal distance between two results
    localparam int group_size = 1 << DECIMATION_LOG2;

    // Cycles since the last result pulse, saturating at the group size
    int cycles_since_pulse;

    always_ff @(posedge clock) begin
        if (rst) begin
            cycles_since_pulse <= group_size;
        end else if (out_valid) begin
            cycles_since_pulse <= 1;
        end else if (cycles_since_pulse < group_size) begin
            cycles_since_pulse <= cycles_since_pulse + 1;
        end
    end

    // Reset clears the result pulse
    reset_clears_output: assert property (@(posedge clock) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // Input may only be taken while the sink allows it
    ready_follows_sink: assert property (@(posedge clock) !out_ready |-> !in_ready)
        else $error("in_ready high while out_ready is low");

    // Flush drops any result that was about to appear
    flush_clears_output: assert property (@(posedge clock) disable iff (rst)
        flush |=> !out_valid)
        else $error("out_valid high in the cycle after flush");

    // Each result needs a full group of samples, one per cycle at most
    result_spacing: assert property (@(posedge clock) disable iff (rst)
        out_valid |-> cycles_since_pulse >= group_size)
        else $error("Two results closer than one group");

endmodule

bind adc_frontend adc_frontend_assertions #(
    .DECIMATION_LOG2(DECIMATION_LOG2)
) frontend_checks (
    .clock(clock),
    .rst(rst),
    .flush(flush),
    .in_ready(in_ready),
    .out_ready(out_ready),
    .out_valid(out_valid)
);

`default_nettype wire

//--- verif/adc_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frontend_tb;

    import adc_pkg::*;

    localparam int data_width = 16;
    localparam int decimation_log2 = 2;
    localparam int group_size = 1 << decimation_log2;
    localparam time clock_period = 20;
    // Upper bound on the driven cycles of all phases together
    localparam int total_stimulus_cycles = 1400;
    localparam time run_limit = (total_stimulus_cycles + 200) * clock_period;

    logic clock;
    logic rst;
    logic flush;
    logic signed [data_width-1:0] in_data;
    logic in_valid;
    logic in_ready;
    logic out_ready;
    logic signed [data_width-1:0] out_data;
    logic out_valid;
    logic config_write;
    config_address_t config_address;
    logic [config_data_width-1:0] config_data;

    // Model state: settings as the DUT should hold them and the open group
    logic signed [15:0] model_offset;
    logic [3:0] model_shift;
    logic model_enable;
    longint model_sum;
    int model_count;
    // The sample of the previous cycle closed a group
    logic group_closed;
    logic signed [data_width-1:0] expected_results[$];
    logic [31:0] lfsr_state;
    int i;
    int j;

    adc_frontend #(
        .DATA_WIDTH(data_width),
        .DECIMATION_LOG2(decimation_log2)
    ) UUT (
        .clock(clock),
        .rst(rst),
        .flush(flush),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .config_write(config_write),
        .config_address(config_address),
        .config_data(config_data)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Taps 32, 22, 2 and 1; the bit shifted in is the one handed out
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] result;
        logic feedback;
        result = '0;
        for (int k = 0; k < count; k++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            result = {result[30:0], feedback};
        end
        return result;
    endfunction

    // Saturate at the rails first, then the shift wraps in the low bits
    function automatic logic signed [data_width-1:0] expected_calibrated(
        input logic signed [data_width-1:0] sample
    );
        longint max_value;
        longint min_value;
        longint total;
        max_value = (longint'(1) << (data_width - 1)) - 1;
        min_value = -(longint'(1) << (data_width - 1));
        total = longint'(sample) + longint'(model_offset);
        if (total > max_value) begin
            total = max_value;
        end else if (total < min_value) begin
            total = min_value;
        end
        if (model_enable) begin
            total = total * (longint'(1) << model_shift);
        end
        return data_width'(total);
    endfunction

    // Floor of the group mean, rounding toward minus infinity
    function automatic logic signed [data_width-1:0] floor_mean(input longint total);
        if (total >= 0) begin
            return data_width'(total / group_size);
        end else begin
            return data_width'(-((-total + group_size - 1) / group_size));
        end
    endfunction

    task automatic report_failure();
        $display("TESTS FAILED");
        $fatal(1, "Stopping on the first error");
    endtask

    task automatic compare_sample(input logic signed [data_width-1:0] actual,
                                  input logic signed [data_width-1:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] out_data: actual %h expected %h", actual, expected);
            report_failure();
        end
    endtask

    task automatic compare_ready(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] in_ready: actual %h expected %h", actual, expected);
            report_failure();
        end
    endtask

    // One cycle of stimulus, applied at the falling edge
    // The model takes the sample with the old settings, then applies any write
    task automatic drive_cycle(input logic valid, input logic [data_width-1:0] data,
                               input logic ready, input logic flush_value,
                               input logic write, input logic [1:0] address,
                               input logic [15:0] write_data);
        @(negedge clock);
        in_valid = valid;
        in_data = data;
        out_ready = ready;
        flush = flush_value;
        config_write = write;
        config_address = config_address_t'(address);
        config_data = write_data;
        if (flush_value) begin
            // The last sample of that group still sits in the calibration register
            // at the flush edge, so its average never comes out
            if (group_closed) begin
                void'(expected_results.pop_back());
            end
            model_sum = 0;
            model_count = 0;
            group_closed = 1'b0;
        end else begin
            group_closed = 1'b0;
            if (valid && ready) begin
                model_sum = model_sum + longint'(expected_calibrated(data));
                model_count = model_count + 1;
                if (model_count == group_size) begin
                    expected_results.push_back(floor_mean(model_sum));
                    model_sum = 0;
                    model_count = 0;
                    group_closed = 1'b1;
                end
            end
        end
        if (write) begin
            case (address)
                2'd0: model_offset = write_data;
                2'd1: model_shift = write_data[3:0];
                2'd2: model_enable = write_data[0];
                default: ;
            endcase
        end
        #1;
        compare_ready(in_ready, ready);
    endtask

    task automatic send_sample(input logic [data_width-1:0] data);
        drive_cycle(1'b1, data, 1'b1, 1'b0, 1'b0, 2'd0, 16'h0);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b1, 1'b0, 1'b0, 2'd0, 16'h0);
    endtask

    task automatic write_setting(input logic [1:0] address, input logic [15:0] data);
        drive_cycle(1'b0, '0, 1'b1, 1'b0, 1'b1, address, data);
    endtask

    // Every result pulse must match the oldest pending average
    always @(negedge clock) begin
        if (!rst && out_valid) begin
            if (expected_results.size() == 0) begin
                $display("A result appeared that no group of samples accounts for");
                report_failure();
            end else begin
                compare_sample(out_data, expected_results.pop_front());
            end
        end
    end

    initial begin
        #(run_limit);
        $display("The run did not finish within its time limit");
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        lfsr_state = 32'h42d94296;
        rst = 1'b1;
        flush = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        config_write = 1'b0;
        config_address = address_offset;
        config_data = '0;
        model_offset = '0;
        model_shift = '0;
        model_enable = 1'b0;
        model_sum = 0;
        model_count = 0;
        group_closed = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // Default settings pass samples through, and address 3 changes nothing
        for (i = 0; i < 32; i++) begin
            send_sample(random_bits(data_width));
        end
        write_setting(2'd3, random_bits(16));
        for (i = 0; i < 16; i++) begin
            send_sample(random_bits(data_width));
        end

        // Large offsets push samples near each rail into saturation
        write_setting(2'd0, 16'h7fff);
        for (i = 0; i < 16; i++) begin
            send_sample({8'h7f, 8'(random_bits(8))});
        end
        write_setting(2'd0, 16'h8000);
        for (i = 0; i < 16; i++) begin
            send_sample({8'h80, 8'(random_bits(8))});
        end

        // Random shifts with gain on, one group per shift value
        write_setting(2'd0, random_bits(16));
        write_setting(2'd2, 16'h0001);
        for (i = 0; i < 40; i++) begin
            write_setting(2'd1, random_bits(16));
            if (random_bits(1)) begin
                write_setting(2'd3, random_bits(16));
            end
            for (j = 0; j < group_size; j++) begin
                send_sample(random_bits(data_width));
            end
        end
        // Gain off makes the shift irrelevant
        write_setting(2'd2, 16'h0000);
        write_setting(2'd1, random_bits(16));
        for (i = 0; i < 32; i++) begin
            send_sample(random_bits(data_width));
        end

        // Random valid gaps
        write_setting(2'd0, random_bits(16));
        for (i = 0; i < 300; i++) begin
            drive_cycle(random_bits(1), random_bits(data_width), 1'b1, 1'b0,
                        1'b0, 2'd0, 16'h0);
        end

        // Sink holds off roughly a quarter of the cycles
        for (i = 0; i < 300; i++) begin
            drive_cycle(random_bits(1), random_bits(data_width), |random_bits(2),
                        1'b0, 1'b0, 2'd0, 16'h0);
        end

        // Partial groups flushed away, at first with samples still in flight
        write_setting(2'd2, 16'h0001);
        write_setting(2'd1, 16'h0003);
        for (i = 0; i < 8; i++) begin
            for (j = 0; j < 3; j++) begin
                idle_cycle();
            end
            for (j = 0; j < (i % group_size) + 1; j++) begin
                send_sample(random_bits(data_width));
            end
            // Later rounds let the pipeline drain before the flush
            if (i >= group_size) begin
                for (j = 0; j < 3; j++) begin
                    idle_cycle();
                end
            end
            // A sample offered in the flush cycle is dropped too
            drive_cycle(i[0], random_bits(data_width), 1'b1, 1'b1, 1'b0, 2'd0, 16'h0);
            for (j = 0; j < 2 * group_size; j++) begin
                send_sample(random_bits(data_width));
            end
        end

        for (i = 0; i < 10; i++) begin
            idle_cycle();
        end

        if (expected_results.size() != 0) begin
            $display("%0d expected results never appeared", expected_results.size());
            $display("TESTS FAILED");
            $fatal(1, "Missing results");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
source/adc_pkg.sv
source/saturating_adder.sv
source/calibration.sv
source/decimator.sv
source/calibration_registers.sv
source/adc_frontend.sv
verif/adc_frontend_assertions.sv
verif/adc_frontend_tb.sv
